// File: compile.f
+incdir+include
logic/video_pkg.sv
logic/beam_if.sv
logic/beam_timing_ctrl.sv
logic/fetch_address_gen.sv
logic/line_buffer.sv
logic/pixel_capture.sv
logic/video_out_stage.sv
logic/video_out_top.sv
sim/video_out_tb.sv

// File: include/video_mode.svh
`ifndef VIDEO_MODE_SVH
`define VIDEO_MODE_SVH

// 720x480 progressive timing, counted in pixel clocks and lines

// Horizontal timing
`define H_TOTAL         858
`define H_VISIBLE       720
`define H_OFFSET        16
`define H_SYNC_START    736
`define H_SYNC_WIDTH    62

// Vertical timing
`define V_LINES         525
`define V_LINES_ADD     526 // One extra line per frame in add-line mode
`define V_VISIBLE       480
`define V_OFFSET        0
`define V_SYNC_START    489
`define V_SYNC_WIDTH    6

// Sync polarity, the level that marks an active pulse
`define HSYNC_ON        1'b0
`define VSYNC_ON        1'b0

`endif

// File: logic/beam_if.sv
`timescale 1ns/1ns

interface beam_if;
    import video_pkg::*;

    beam_count_t beam_x;
    beam_count_t beam_y;
    logic        fetch_window; // Beam is inside the part of the screen that shows buffer data
    logic        line_doubler; // Registered mode, changes only together with a restart

    modport ctrl (
        output beam_x,
        output beam_y,
        output fetch_window,
        output line_doubler
    );

    modport fetch (
        input beam_x,
        input beam_y,
        input fetch_window,
        input line_doubler
    );

endinterface

// File: logic/beam_timing_ctrl.sv
`timescale 1ns/1ns

module beam_timing_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic start_strobe,
    input  logic line_doubler,
    input  logic add_line,
    beam_if.ctrl beam,
    output logic hsync,
    output logic vsync,
    output logic draw_area
);
    import video_pkg::*;

    beam_count_t x_count;
    beam_count_t y_count;
    beam_count_t x_q;
    beam_count_t y_q;
    beam_count_t v_total;
    logic        running;
    logic        running_q;
    logic        beam_valid;
    logic        line_doubler_reg;
    logic        add_line_reg;
    logic        restart;
    logic        hsync_q;
    logic        vsync_q;
    logic        hsync_next;
    logic        vsync_next;

    assign v_total    = add_line_reg ? V_LINES_ADD : V_LINES;
    assign restart    = (line_doubler != line_doubler_reg) || (add_line != add_line_reg);
    assign beam_valid = running && running_q; // x_q and y_q hold a live position

    // --------------------------------------------------
    // Beam counters

    always_ff @(posedge clock) begin
        if (!reset) begin
            running          <= 1'b0;
            running_q        <= 1'b0;
            line_doubler_reg <= 1'b0;
            add_line_reg     <= 1'b0;
            x_count          <= H_OFFSET;
            y_count          <= V_OFFSET;
        end else begin
            line_doubler_reg <= line_doubler;
            add_line_reg     <= add_line;
            running_q        <= running;
            if (restart) begin
                running <= 1'b0; // Wait for the next frame start in the new mode
                x_count <= H_OFFSET;
                y_count <= V_OFFSET;
            end else if (!running && start_strobe) begin
                running <= 1'b1;
                x_count <= H_OFFSET;
                y_count <= V_OFFSET;
            end else if (running) begin
                if (x_count == H_TOTAL - 1'b1) begin
                    x_count <= '0;
                    if (y_count == v_total - 1'b1) begin
                        y_count <= '0;
                    end else begin
                        y_count <= y_count + 1'b1;
                    end
                end else begin
                    x_count <= x_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (running) begin
            x_q <= x_count;
            y_q <= y_count;
        end
    end

    // --------------------------------------------------
    // Sync generation

    assign hsync_next = (x_q >= H_SYNC_START) && (x_q < H_SYNC_START + H_SYNC_WIDTH);

    // Vertical pulse opens and closes on the hsync leading edge
    assign vsync_next = ((y_q == V_SYNC_START) && (x_q >= H_SYNC_START))
                     || ((y_q > V_SYNC_START) && (y_q < V_SYNC_START + V_SYNC_WIDTH))
                     || ((y_q == V_SYNC_START + V_SYNC_WIDTH) && (x_q < H_SYNC_START));

    always_ff @(posedge clock) begin
        if (!reset || restart) begin
            hsync_q <= ~HSYNC_ON;
            vsync_q <= ~VSYNC_ON;
        end else if (beam_valid) begin
            hsync_q <= hsync_next ? HSYNC_ON : ~HSYNC_ON;
            vsync_q <= vsync_next ? VSYNC_ON : ~VSYNC_ON;
        end
    end

    assign hsync     = hsync_q;
    assign vsync     = vsync_q;
    assign draw_area = beam_valid && (x_q < H_VISIBLE) && (y_q < V_VISIBLE); // Registered again downstream

    assign beam.beam_x       = x_count;
    assign beam.beam_y       = y_count;
    assign beam.line_doubler = line_doubler_reg;
    assign beam.fetch_window = running
                            && (x_count >= H_OFFSET) && (x_count < H_VISIBLE - H_OFFSET)
                            && (y_count >= V_OFFSET) && (y_count < V_VISIBLE - V_OFFSET);

    // The registered sync trails the live counter by two clocks
    hsync_in_window: assert property (@(posedge clock) disable iff (!reset)
        (hsync_q == HSYNC_ON) |-> (x_count >= H_SYNC_START + 12'd2)
                                  && (x_count < H_SYNC_START + H_SYNC_WIDTH + 12'd2));

    counters_in_range: assert property (@(posedge clock) disable iff (!reset)
        (x_count < H_TOTAL) && (y_count < v_total));

endmodule

// File: logic/fetch_address_gen.sv
`timescale 1ns/1ns

module fetch_address_gen #(
    parameter int PIXEL_FACTOR = 2
) (
    beam_if.fetch                  beam,
    output video_pkg::buffer_addr_u read_address
);
    import video_pkg::*;

    localparam int          COLUMN_OFFSET = H_OFFSET / PIXEL_FACTOR;
    localparam logic [11:0] PARK_ADDRESS  = 12'd1023; // Read from here while the window is closed

    logic [10:0] scaled_x;

    // Each buffer word covers PIXEL_FACTOR screen pixels
    assign scaled_x = (PIXEL_FACTOR == 2) ? beam.beam_x[11:1] : beam.beam_x[10:0];

    always_comb begin
        read_address = PARK_ADDRESS;
        if (beam.fetch_window) begin
            if (beam.line_doubler) begin
                read_address.doubled.bank   = beam.beam_y[2:1]; // Two screen lines per bank
                read_address.doubled.column = beam.beam_x[9:0] - 10'(COLUMN_OFFSET);
            end else begin
                read_address.single.pad    = 1'b0;
                read_address.single.column = scaled_x - 11'(COLUMN_OFFSET);
            end
        end
    end

endmodule

// File: logic/line_buffer.sv
`timescale 1ns/1ns

module line_buffer (
    input  logic                    clock,
    input  logic                    write_enable,
    input  video_pkg::buffer_addr_u write_address,
    input  video_pkg::pixel_t       write_data,
    input  video_pkg::buffer_addr_u read_address,
    output video_pkg::pixel_t       read_data
);
    import video_pkg::*;

    localparam int DEPTH = 4096;

    // Four banks of 1024 words, the bank sits in the top two address bits
    pixel_t      memory [0:DEPTH-1];
    logic [11:0] write_index;
    logic [11:0] read_index;

    assign write_index = write_address;
    assign read_index  = read_address;

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_index] <= write_data;
        end
    end

    // A read of the word being written returns the old contents
    always_ff @(posedge clock) begin
        read_data <= memory[read_index];
    end

endmodule

// File: logic/pixel_capture.sv
`timescale 1ns/1ns

module pixel_capture #(
    parameter int PIXEL_FACTOR = 2
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    pixel_valid,
    input  logic                    line_start,
    input  logic                    frame_start,
    input  video_pkg::pixel_t       pixel_in,
    input  logic                    line_doubler,
    output logic                    write_enable,
    output video_pkg::buffer_addr_u write_address,
    output video_pkg::pixel_t       write_data,
    output logic                    start_strobe
);
    import video_pkg::*;

    // Words needed for one visible line in each layout
    localparam logic [10:0] SINGLE_WORDS  = 11'(H_VISIBLE / PIXEL_FACTOR);
    localparam logic [10:0] DOUBLED_WORDS = 11'(H_VISIBLE);

    logic [10:0] column;
    logic [1:0]  bank;
    logic [10:0] column_now;
    logic [1:0]  bank_now;
    logic [10:0] line_words;

    // A strobe in the same cycle as a pixel already applies to that pixel
    assign column_now = line_start ? '0 : column;
    assign bank_now   = frame_start ? '0 : (line_start ? bank + 2'd1 : bank);
    assign line_words = line_doubler ? DOUBLED_WORDS : SINGLE_WORDS;

    always_ff @(posedge clock) begin
        if (!reset) begin
            column       <= '0;
            bank         <= '0;
            write_enable <= 1'b0;
            start_strobe <= 1'b0;
        end else begin
            start_strobe <= frame_start;
            write_enable <= pixel_valid && (column_now < line_words); // Excess pixels are dropped
            bank         <= bank_now;
            column       <= pixel_valid ? column_now + 11'd1 : column_now;
        end
    end

    always_ff @(posedge clock) begin
        write_data <= pixel_in;
        if (line_doubler) begin
            write_address.doubled.bank   <= bank_now;
            write_address.doubled.column <= column_now[9:0];
        end else begin
            write_address.single.pad    <= 1'b0;
            write_address.single.column <= column_now;
        end
    end

    column_in_range: assert property (@(posedge clock) disable iff (!reset)
        pixel_valid |-> (column_now <= 11'd1023));

endmodule

// File: logic/video_out_stage.sv
`timescale 1ns/1ns

module video_out_stage (
    input  logic              clock,
    input  logic              reset,
    input  video_pkg::pixel_t read_data,
    input  logic              draw_area_early,
    beam_if.fetch             beam,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    output logic              draw_area
);
    import video_pkg::*;

    logic   window_q;
    pixel_t pixel_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            window_q  <= 1'b0;
            pixel_q   <= '0;
            draw_area <= 1'b0;
        end else begin
            window_q  <= beam.fetch_window; // Lines up with the RAM read latency
            pixel_q   <= window_q ? read_data : '0;
            draw_area <= draw_area_early;
        end
    end

    assign red   = pixel_q[23:16];
    assign green = pixel_q[15:8];
    assign blue  = pixel_q[7:0];

endmodule

// File: logic/video_out_top.sv
`timescale 1ns/1ns

module video_out_top #(
    parameter int PIXEL_FACTOR = 2
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              pixel_valid,
    input  logic              line_start,
    input  logic              frame_start,
    input  video_pkg::pixel_t pixel_in,
    input  logic              line_doubler,
    input  logic              add_line,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    output logic              hsync,
    output logic              vsync,
    output logic              draw_area
);
    import video_pkg::*;

    logic         write_enable;
    buffer_addr_u write_address;
    pixel_t       write_data;
    buffer_addr_u read_address;
    pixel_t       read_data;
    logic         start_strobe;
    logic         draw_area_early;

    beam_if beam ();

    // --------------------------------------------------
    // Write side

    pixel_capture #(.PIXEL_FACTOR(PIXEL_FACTOR)) capture (
        .clock, .reset, .pixel_valid, .line_start, .frame_start, .pixel_in, .line_doubler,
        .write_enable, .write_address, .write_data, .start_strobe
    );

    line_buffer line_buf (
        .clock, .write_enable, .write_address, .write_data, .read_address, .read_data
    );

    // --------------------------------------------------
    // Read side

    beam_timing_ctrl timing (
        .clock, .reset, .start_strobe, .line_doubler, .add_line,
        .beam(beam.ctrl), .hsync, .vsync, .draw_area(draw_area_early)
    );

    fetch_address_gen #(.PIXEL_FACTOR(PIXEL_FACTOR)) fetch_addr (
        .beam(beam.fetch), .read_address
    );

    video_out_stage out_stage (
        .clock, .reset, .read_data, .draw_area_early, .beam(beam.fetch),
        .red, .green, .blue, .draw_area
    );

endmodule

// File: logic/video_pkg.sv
package video_pkg;

`include "video_mode.svh"

    typedef logic [23:0] pixel_t; // Red in the top byte, blue in the bottom byte

    typedef logic [11:0] beam_count_t;

    // Line buffer address, read as bank and column when lines are doubled
    typedef union packed {
        struct packed {
            logic [1:0] bank;
            logic [9:0] column;
        } doubled;
        struct packed {
            logic        pad;
            logic [10:0] column;
        } single;
    } buffer_addr_u;

    // --------------------------------------------------
    // Mode timing

    localparam beam_count_t H_TOTAL      = beam_count_t'(`H_TOTAL);
    localparam beam_count_t H_VISIBLE    = beam_count_t'(`H_VISIBLE);
    localparam beam_count_t H_OFFSET     = beam_count_t'(`H_OFFSET);
    localparam beam_count_t H_SYNC_START = beam_count_t'(`H_SYNC_START);
    localparam beam_count_t H_SYNC_WIDTH = beam_count_t'(`H_SYNC_WIDTH);

    localparam beam_count_t V_LINES      = beam_count_t'(`V_LINES);
    localparam beam_count_t V_LINES_ADD  = beam_count_t'(`V_LINES_ADD);
    localparam beam_count_t V_VISIBLE    = beam_count_t'(`V_VISIBLE);
    localparam beam_count_t V_OFFSET     = beam_count_t'(`V_OFFSET);
    localparam beam_count_t V_SYNC_START = beam_count_t'(`V_SYNC_START);
    localparam beam_count_t V_SYNC_WIDTH = beam_count_t'(`V_SYNC_WIDTH);

    localparam logic HSYNC_ON = `HSYNC_ON;
    localparam logic VSYNC_ON = `VSYNC_ON;

endpackage

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module video_out_tb \
    -o video_out_sim

./obj_dir/video_out_sim

// File: sim/video_out_tb.sv
`timescale 1ns/1ns

module video_out_tb;
    import video_pkg::*;

    localparam int PIXEL_FACTOR    = 2;
    localparam int NUM_ROWS        = 4;
    localparam int COLUMN_OFFSET   = int'(H_OFFSET) / PIXEL_FACTOR;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 3 * int'(V_LINES_ADD) * int'(H_TOTAL);

    typedef struct packed {
        logic        line_doubler;
        logic        add_line;
        beam_count_t frame_lines;
        beam_count_t active_pixels;
    } row_t;

    logic       clock;
    logic       reset;
    logic       pixel_valid;
    logic       line_start;
    logic       frame_start;
    pixel_t     pixel_in;
    logic       line_doubler;
    logic       add_line;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       hsync;
    logic       vsync;
    logic       draw_area;

    row_t   rows [0:NUM_ROWS-1];
    pixel_t stored [0:4095]; // Expected contents of the line buffer

    video_out_top #(.PIXEL_FACTOR(PIXEL_FACTOR)) dut0 (
        .clock, .reset, .pixel_valid, .line_start, .frame_start, .pixel_in,
        .line_doubler, .add_line, .red, .green, .blue, .hsync, .vsync, .draw_area
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout, the run did not finish within %0d clocks", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Compare tasks

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_count(input string name, input beam_count_t got, input beam_count_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // --------------------------------------------------
    // Stimulus

    task automatic step();
        @(posedge clock);
        #1; // Outputs are settled here and inputs change here
    endtask

    task automatic check_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            check_bit("hsync", hsync, ~HSYNC_ON);
            check_bit("vsync", vsync, ~VSYNC_ON);
            check_bit("draw_area", draw_area, 1'b0);
            check_pixel("rgb", {red, green, blue}, '0);
            step();
        end
    endtask

    task automatic load_lines(input logic doubled);
        int          words;
        int          line;
        int          col;
        logic [1:0]  bank;
        logic [11:0] addr;
        pixel_t      value;
        words = doubled ? int'(H_VISIBLE) : int'(H_VISIBLE) / PIXEL_FACTOR;
        bank  = 2'd0; // Cleared by reset and by every frame start
        for (line = 0; line < 4; line++) begin
            bank = bank + 2'd1;
            for (col = 0; col < words; col++) begin
                value        = {bank, 10'(col), 12'($urandom)};
                addr         = doubled ? {bank, 10'(col)} : {1'b0, 11'(col)};
                stored[addr] = value;
                pixel_valid  = 1'b1;
                line_start   = (col == 0);
                pixel_in     = value;
                step();
            end
        end
        pixel_valid = 1'b0;
        line_start  = 1'b0;
        pixel_in    = '0;
    endtask

    task automatic wait_vsync_start();
        logic prev;
        int   count;
        prev  = vsync;
        count = 0;
        while (!(prev != VSYNC_ON && vsync == VSYNC_ON)) begin
            if (count == 2 * int'(V_LINES_ADD) * int'(H_TOTAL)) begin
                $display("no vsync pulse appeared after the frame start");
                $display("Something failed");
                $fatal(1, "vsync missing");
            end else begin
                prev = vsync;
                step();
                count++;
            end
        end
    endtask

    // Starts on the vsync leading edge, where the beam is at the sync start of both axes
    task automatic observe_frame(input logic doubled, input beam_count_t lines,
                                 input beam_count_t active);
        beam_count_t x;
        beam_count_t y;
        beam_count_t word_x;
        beam_count_t edges;
        beam_count_t sync_lines;
        beam_count_t line_draw;
        beam_count_t draw_lines;
        logic [11:0] addr;
        logic        hs_prev;
        logic        vs_on;
        logic        window;
        int          i;
        int          last_edge;
        int          position;
        int          vsync_begin;
        x           = H_SYNC_START;
        y           = V_SYNC_START;
        edges       = '0;
        sync_lines  = '0;
        line_draw   = '0;
        draw_lines  = '0;
        last_edge   = 0;
        hs_prev     = hsync;
        vsync_begin = int'(V_SYNC_START) * int'(H_TOTAL) + int'(H_SYNC_START);
        for (i = 0; i <= int'(lines) * int'(H_TOTAL); i++) begin
            if (i > 0) begin
                step();
                x = x + 12'd1;
                if (x == H_TOTAL) begin
                    x = '0;
                    y = (y == lines - 12'd1) ? '0 : y + 12'd1;
                end
            end
            // Vsync covers whole lines measured from one hsync leading edge
            position = int'(y) * int'(H_TOTAL) + int'(x);
            vs_on = (position >= vsync_begin)
                 && (position < vsync_begin + int'(V_SYNC_WIDTH) * int'(H_TOTAL));
            window = (x >= H_OFFSET) && (x < H_VISIBLE - H_OFFSET)
                  && (y >= V_OFFSET) && (y < V_VISIBLE - V_OFFSET);
            word_x = (doubled ? x : x / beam_count_t'(PIXEL_FACTOR))
                   - beam_count_t'(COLUMN_OFFSET);
            addr = doubled ? {y[2:1], word_x[9:0]} : {1'b0, word_x[10:0]};
            check_bit("hsync", hsync, ((x >= H_SYNC_START) && (x < H_SYNC_START + H_SYNC_WIDTH))
                                      ? HSYNC_ON : ~HSYNC_ON);
            check_bit("vsync", vsync, vs_on ? VSYNC_ON : ~VSYNC_ON);
            check_bit("draw_area", draw_area, (x < H_VISIBLE) && (y < V_VISIBLE));
            check_pixel("rgb", {red, green, blue}, window ? stored[addr] : '0);
            if (i > 0 && hsync == HSYNC_ON && hs_prev != HSYNC_ON) begin
                edges = edges + 12'd1;
                if (vsync == VSYNC_ON) sync_lines = sync_lines + 12'd1;
                check_count("hsync period", beam_count_t'(i - last_edge), H_TOTAL);
                last_edge = i;
            end
            hs_prev = hsync;
            if (draw_area) line_draw = line_draw + 12'd1;
            if (x == H_TOTAL - 12'd1) begin
                if (line_draw != '0) begin
                    check_count("draw_area cycles per line", line_draw, active);
                    draw_lines = draw_lines + 12'd1;
                end
                line_draw = '0;
            end
        end
        check_count("lines per frame", edges, lines);
        check_count("vsync lines", sync_lines, V_SYNC_WIDTH);
        check_count("visible lines", draw_lines, V_VISIBLE);
    endtask

    // --------------------------------------------------
    // Main sequence

    initial begin
        int r;
        void'($urandom(32'h6a4e_5501));
        reset        = 1'b0;
        pixel_valid  = 1'b0;
        line_start   = 1'b0;
        frame_start  = 1'b0;
        pixel_in     = '0;
        line_doubler = 1'b0;
        add_line     = 1'b0;
        // Each row after the first changes the mode and so restarts a running frame
        rows[0] = '{1'b0, 1'b0, V_LINES, H_VISIBLE};
        rows[1] = '{1'b1, 1'b0, V_LINES, H_VISIBLE};
        rows[2] = '{1'b1, 1'b1, V_LINES_ADD, H_VISIBLE};
        rows[3] = '{1'b0, 1'b1, V_LINES_ADD, H_VISIBLE};
        repeat (10) @(posedge clock);
        #1 reset = 1'b1;
        for (r = 0; r < NUM_ROWS; r++) begin
            line_doubler = rows[r].line_doubler;
            add_line     = rows[r].add_line;
            repeat (4) step(); // Pipeline drains after the restart
            check_idle(2 * int'(H_TOTAL));
            load_lines(rows[r].line_doubler);
            frame_start = 1'b1;
            step();
            frame_start = 1'b0;
            wait_vsync_start();
            observe_frame(rows[r].line_doubler, rows[r].frame_lines, rows[r].active_pixels);
        end
        $display("Everything OK");
        $finish;
    end

endmodule
